/* Makefile */
VERILATOR ?= verilator
TOP ?= cpu_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
src/cpu_pkg.sv
src/ex_mem_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/hazard_unit.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu.sv
bench/clock_gen.sv
bench/cpu_tb.sv

/* bench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic reset
);
	localparam realtime HALF_PERIOD = 50ns;
	localparam int RESET_CYCLES = 5;

	// 100 ns free-running clock
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Power-on reset
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

/* bench/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();
	localparam int NUM_ROWS = 8;
	localparam int MAX_WORDS = 12;
	localparam int MAX_RETIRE = 8;
	localparam int HALT_TIMEOUT = 200;
	localparam int POR_TIMEOUT = 20;
	localparam int RND_ROW = 7;
	localparam word_t HLT_WORD = 16'hF000;

	logic clk, por, load_reset;
	logic imem_we;
	logic [IMEM_AW-1:0] imem_addr;
	word_t imem_wdata;
	word_t pc, wb_data;
	logic hlt, wb_en;
	reg_idx_t wb_rd;

	// Program being loaded and retirements seen
	word_t load_buf [$];
	reg_idx_t got_rd [$];
	word_t got_data [$];

	// ------------------------------------------------------------------------
	// Stimulus table with expected {rd, data} entries
	// ------------------------------------------------------------------------
	string row_name [NUM_ROWS] = '{"alu_ops", "add_sub_sat", "forward_chain",
		"load_store", "branch_cond", "br_pcs", "halt_stop", "random_sum"};
	word_t row_prog [NUM_ROWS][MAX_WORDS] = '{
		'{16'hB134, 16'hA112, 16'hB20F, 16'h2312, 16'h3412, 16'h4514,
			16'h5614, 16'h6714, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
		'{16'hB1FF, 16'hA17F, 16'hB201, 16'h0312, 16'h1421, 16'hA280,
			16'h1521, 16'h0632, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
		'{16'hB105, 16'h0211, 16'h0321, 16'h0432, 16'h0541, 16'hF000,
			16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
		'{16'hB140, 16'hB2CD, 16'hA2AB, 16'h9212, 16'h8312, 16'h0433,
			16'h2532, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
		'{16'hB103, 16'h1211, 16'hC202, 16'hB311, 16'hB422, 16'hB533,
			16'hC002, 16'hB644, 16'h1721, 16'hC601, 16'hB855, 16'hF000},
		'{16'hE100, 16'hB20C, 16'hD020, 16'hB311, 16'hB422, 16'hB533,
			16'hE500, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
		'{16'hB107, 16'hF000, 16'hB208, 16'hB309, 16'hF000, 16'hF000,
			16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000},
		// Filled in from random operands at start
		'{16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000,
			16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000, 16'hF000}
	};
	int row_count [NUM_ROWS] = '{8, 8, 5, 6, 5, 3, 1, 6};
	logic [19:0] row_exp [NUM_ROWS][MAX_RETIRE] = '{
		'{20'h1_0034, 20'h1_1234, 20'h2_000F, 20'h3_123B,
			20'h4_0004, 20'h5_2340, 20'h6_0123, 20'h7_4123},
		// Saturation on both ends and then an exact zero sum
		'{20'h1_00FF, 20'h1_7FFF, 20'h2_0001, 20'h3_7FFF,
			20'h4_8002, 20'h2_8001, 20'h5_8000, 20'h6_0000},
		'{20'h1_0005, 20'h2_000A, 20'h3_000F, 20'h4_0019,
			20'h5_001E, 20'h0, 20'h0, 20'h0},
		'{20'h1_0040, 20'h2_00CD, 20'h2_ABCD, 20'h3_ABCD,
			20'h4_8000, 20'h5_0000, 20'h0, 20'h0},
		// Taken EQ, untaken NE, taken LT
		'{20'h1_0003, 20'h2_0000, 20'h5_0033, 20'h6_0044,
			20'h7_FFFD, 20'h0, 20'h0, 20'h0},
		'{20'h1_0002, 20'h2_000C, 20'h5_000E, 20'h0,
			20'h0, 20'h0, 20'h0, 20'h0},
		'{20'h1_0007, 20'h0, 20'h0, 20'h0, 20'h0, 20'h0, 20'h0, 20'h0},
		'{20'h0, 20'h0, 20'h0, 20'h0, 20'h0, 20'h0, 20'h0, 20'h0}
	};
	// Fetch PC parked one word past the HLT that executes
	word_t row_halt_pc [NUM_ROWS] = '{16'h0012, 16'h0012, 16'h000C, 16'h0010,
		16'h0018, 16'h0010, 16'h0004, 16'h000E};

	clock_gen u_clk (.clk, .reset(por));

	cpu UUT (
		.clk, .reset(por | load_reset),
		.imem_we, .imem_addr, .imem_wdata,
		.pc, .hlt, .wb_en, .wb_rd, .wb_data
	);

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_word(input string test, input word_t exp, input word_t act);
		if (act !== exp)
			abort_run($sformatf("** Error %s: expected %h, actual %h", test, exp, act));
	endtask

	task automatic check_reg(input string test, input reg_idx_t exp, input reg_idx_t act);
		if (act !== exp)
			abort_run($sformatf("** Error %s: expected R%0d, actual R%0d", test, exp, act));
	endtask

	task automatic check_count(input string test, input int exp, input int act);
		if (act != exp)
			abort_run($sformatf("** Error %s: expected %0d retirements, actual %0d",
				test, exp, act));
	endtask

	// Signed sum or difference clamped to 16 bits
	function automatic word_t sat_result(input word_t a, input word_t b, input logic sub);
		int s;
		if (sub)
			s = int'($signed(a)) - int'($signed(b));
		else
			s = int'($signed(a)) + int'($signed(b));
		if (s > 32767)
			s = 32767;
		else if (s < -32768)
			s = -32768;
		return word_t'(s);
	endfunction

	// ------------------------------------------------------------------------
	// Load under reset, run, collect retirements until hlt
	// ------------------------------------------------------------------------
	task automatic load_and_run(input string test, input word_t halt_pc);
		int cycles;
		logic done;
		@(posedge clk);
		load_reset <= 1'b1;
		for (int i = 0; i < load_buf.size(); i++) begin
			@(posedge clk);
			imem_we <= 1'b1;
			imem_addr <= IMEM_AW'(i);
			imem_wdata <= load_buf[i];
		end
		@(posedge clk);
		imem_we <= 1'b0;
		@(posedge clk);
		load_reset <= 1'b0;
		got_rd.delete();
		got_data.delete();
		cycles = 0;
		done = 1'b0;
		// Sampled on the falling edge away from DUT updates
		while (!done) begin
			@(negedge clk);
			if (wb_en) begin
				got_rd.push_back(wb_rd);
				got_data.push_back(wb_data);
			end
			if (hlt)
				done = 1'b1;
			else begin
				cycles++;
				if (cycles > HALT_TIMEOUT)
					abort_run($sformatf("Timeout: %s did not raise hlt in %0d cycles",
						test, HALT_TIMEOUT));
			end
		end
		// Nothing younger than HLT may retire
		repeat (4) begin
			@(negedge clk);
			if (wb_en)
				abort_run($sformatf("%s retired an instruction after the halt", test));
		end
		check_word(test, halt_pc, pc);
	endtask

	// LLB then SLL by 8 leaves every register at zero
	task automatic clear_regs();
		load_buf.delete();
		for (int r = 0; r < NUM_REGS; r++) begin
			load_buf.push_back({4'hB, 4'(r), 8'h00});
			load_buf.push_back({4'h4, 4'(r), 4'(r), 4'h8});
		end
		load_buf.push_back(HLT_WORD);
		// HLT sits at word 2 * NUM_REGS
		load_and_run("clear_regs", word_t'(4 * NUM_REGS + 2));
		check_count("clear_regs", 2 * NUM_REGS, got_rd.size());
		for (int r = 0; r < NUM_REGS; r++) begin
			check_reg("clear_regs", reg_idx_t'(r), got_rd[2 * r]);
			check_reg("clear_regs", reg_idx_t'(r), got_rd[2 * r + 1]);
			check_word("clear_regs", 16'h0000, got_data[2 * r + 1]);
		end
	endtask

	task automatic run_row(input int row);
		int n;
		clear_regs();
		load_buf.delete();
		for (int i = 0; i < MAX_WORDS; i++)
			load_buf.push_back(row_prog[row][i]);
		load_and_run(row_name[row], row_halt_pc[row]);
		n = row_count[row];
		check_count(row_name[row], n, got_rd.size());
		for (int i = 0; i < n; i++) begin
			check_reg(row_name[row], reg_idx_t'(row_exp[row][i][19:16]), got_rd[i]);
			check_word(row_name[row], row_exp[row][i][15:0], got_data[i]);
		end
	endtask

	// Two random constants followed by their ADD and SUB
	task automatic build_random_row();
		word_t a, b;
		a = word_t'($urandom());
		b = word_t'($urandom());
		row_prog[RND_ROW][0] = {4'hB, 4'h1, a[7:0]};
		row_prog[RND_ROW][1] = {4'hA, 4'h1, a[15:8]};
		row_prog[RND_ROW][2] = {4'hB, 4'h2, b[7:0]};
		row_prog[RND_ROW][3] = {4'hA, 4'h2, b[15:8]};
		row_prog[RND_ROW][4] = 16'h0312;
		row_prog[RND_ROW][5] = 16'h1412;
		row_exp[RND_ROW][0] = {4'h1, 8'h00, a[7:0]};
		row_exp[RND_ROW][1] = {4'h1, a};
		row_exp[RND_ROW][2] = {4'h2, 8'h00, b[7:0]};
		row_exp[RND_ROW][3] = {4'h2, b};
		row_exp[RND_ROW][4] = {4'h3, sat_result(a, b, 1'b0)};
		row_exp[RND_ROW][5] = {4'h4, sat_result(a, b, 1'b1)};
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		int waited;
		load_reset = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		void'($urandom(32'hbdff));
		build_random_row();
		waited = 0;
		while (por !== 1'b0) begin
			@(negedge clk);
			waited++;
			if (waited > POR_TIMEOUT)
				abort_run("Timeout: power-on reset was never released");
		end
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* src/cpu.sv */
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic imem_we,
	input logic [IMEM_AW-1:0] imem_addr,
	input word_t imem_wdata,
	output word_t pc,
	output logic hlt,
	output logic wb_en,
	output reg_idx_t wb_rd,
	output word_t wb_data
);
	// Hazard and control
	logic stall, halt_seen, branch_taken;
	word_t branch_target;
	fwd_sel_t fwd_a, fwd_b;

	// IF/ID
	word_t ifid_pc, ifid_instr;
	logic ifid_valid;
	reg_idx_t rs_idx, rt_idx;

	// ID/EX
	word_t idex_pc, idex_instr, idex_data1, idex_data2;
	opcode_t idex_op;
	reg_idx_t idex_rs, idex_rt, idex_rd;
	logic idex_regwrite, idex_memtoreg, idex_memwrite, idex_halt;

	// MEM result fed back into EX
	word_t mem_fwd;

	ex_mem_if em_bus ();

	// -------------------------------------------------------------------------
	// Stages
	// -------------------------------------------------------------------------
	fetch_stage u_fetch (
		.clk, .reset, .imem_we, .imem_addr, .imem_wdata,
		.stall, .halt_seen, .branch_taken, .branch_target,
		.pc, .ifid_pc, .ifid_instr, .ifid_valid
	);

	// Taken branch doubles as the ID/EX flush
	decode_stage u_decode (
		.clk, .reset, .stall, .flush(branch_taken),
		.ifid_pc, .ifid_instr, .ifid_valid, .wb_en, .wb_rd, .wb_data,
		.halt_seen, .rs_idx, .rt_idx,
		.idex_pc, .idex_instr, .idex_op, .idex_rs, .idex_rt,
		.idex_data1, .idex_data2, .idex_rd,
		.idex_regwrite, .idex_memtoreg, .idex_memwrite, .idex_halt
	);

	hazard_unit u_hazard (
		.idex_rs, .idex_rt, .idex_memtoreg, .idex_rd,
		.ifid_rs(rs_idx), .ifid_rt(rt_idx),
		.em(em_bus.monitor), .wb_en, .wb_rd,
		.stall, .fwd_a, .fwd_b
	);

	execute_stage u_execute (
		.clk, .reset,
		.idex_pc, .idex_instr, .idex_op, .idex_data1, .idex_data2, .idex_rd,
		.idex_regwrite, .idex_memtoreg, .idex_memwrite, .idex_halt,
		.fwd_a, .fwd_b, .mem_fwd, .wb_data,
		.em(em_bus.producer), .branch_taken, .branch_target
	);

	memory_stage u_memory (
		.clk, .reset, .em(em_bus.consumer),
		.mem_fwd, .wb_en, .wb_rd, .wb_data, .hlt
	);

endmodule

/* src/cpu_pkg.sv */
package cpu_pkg;

	// Machine word, used for both data and byte addresses
	typedef logic [15:0] word_t;
	typedef logic [3:0] reg_idx_t;

	// Memory sizes in 16-bit words
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;
	localparam int IMEM_AW = 8;
	localparam int DMEM_AW = 8;
	localparam int NUM_REGS = 16;

	// Instruction classes in bits 15..12
	typedef enum logic [3:0] {
		OP_ADD = 4'h0,
		OP_SUB = 4'h1,
		OP_XOR = 4'h2,
		OP_AND = 4'h3,
		OP_SLL = 4'h4,
		OP_SRA = 4'h5,
		OP_ROR = 4'h6,
		OP_NOP = 4'h7,	// unused encoding, also marks pipeline bubbles
		OP_LW = 4'h8,
		OP_SW = 4'h9,
		OP_LHB = 4'hA,
		OP_LLB = 4'hB,
		OP_B = 4'hC,
		OP_BR = 4'hD,
		OP_PCS = 4'hE,
		OP_HLT = 4'hF
	} opcode_t;

	// Branch conditions in bits 11..9 of B
	typedef enum logic [2:0] {
		COND_NE = 3'd0,
		COND_EQ = 3'd1,
		COND_GT = 3'd2,
		COND_LT = 3'd3,
		COND_GE = 3'd4,
		COND_LE = 3'd5,
		COND_OV = 3'd6,
		COND_ALWAYS = 3'd7
	} cond_t;

	// ALU operand source
	typedef enum logic [1:0] {FWD_NONE = 2'd0, FWD_MEM = 2'd1, FWD_WB = 2'd2} fwd_sel_t;

	typedef struct packed {logic z; logic v; logic n;} flags_t;

endpackage

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic flush,
	input word_t ifid_pc,
	input word_t ifid_instr,
	input logic ifid_valid,
	input logic wb_en,
	input reg_idx_t wb_rd,
	input word_t wb_data,
	output logic halt_seen,
	output reg_idx_t rs_idx,
	output reg_idx_t rt_idx,
	output word_t idex_pc,
	output word_t idex_instr,
	output opcode_t idex_op,
	output reg_idx_t idex_rs,
	output reg_idx_t idex_rt,
	output word_t idex_data1,
	output word_t idex_data2,
	output reg_idx_t idex_rd,
	output logic idex_regwrite,
	output logic idex_memtoreg,
	output logic idex_memwrite,
	output logic idex_halt
);
	word_t regs [NUM_REGS];
	word_t instr;
	opcode_t op;
	word_t data1, data2;
	logic regwrite;

	// -------------------------------------------------------------------------
	// Field decode
	// -------------------------------------------------------------------------
	// Invalid slot decodes as NOP with zero fields
	assign instr = ifid_valid ? ifid_instr : '0;
	assign op = ifid_valid ? opcode_t'(ifid_instr[15:12]) : OP_NOP;

	// SW, LHB and LLB read rd first; SW takes its base from rs
	assign rs_idx = (op inside {OP_SW, OP_LHB, OP_LLB}) ? instr[11:8] : instr[7:4];
	assign rt_idx = (op == OP_SW) ? instr[7:4] : instr[3:0];
	assign halt_seen = (op == OP_HLT);

	always_comb begin
		case (op)
			OP_SW, OP_B, OP_BR, OP_HLT, OP_NOP: regwrite = 1'b0;
			default: regwrite = 1'b1;
		endcase
	end

	// -------------------------------------------------------------------------
	// Register file
	// -------------------------------------------------------------------------
	always_ff @(posedge clk)
		if (wb_en)
			regs[wb_rd] <= wb_data;

	// Same-cycle writeback shows up on the read side
	assign data1 = (wb_en && wb_rd == rs_idx) ? wb_data : regs[rs_idx];
	assign data2 = (wb_en && wb_rd == rt_idx) ? wb_data : regs[rt_idx];

	// -------------------------------------------------------------------------
	// ID/EX register
	// -------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || flush || stall) begin
			// Bubble
			idex_pc <= '0;
			idex_instr <= '0;
			idex_op <= OP_NOP;
			idex_rs <= '0;
			idex_rt <= '0;
			idex_data1 <= '0;
			idex_data2 <= '0;
			idex_rd <= '0;
			idex_regwrite <= 1'b0;
			idex_memtoreg <= 1'b0;
			idex_memwrite <= 1'b0;
			idex_halt <= 1'b0;
		end else begin
			idex_pc <= ifid_pc;
			idex_instr <= instr;
			idex_op <= op;
			idex_rs <= rs_idx;
			idex_rt <= rt_idx;
			idex_data1 <= data1;
			idex_data2 <= data2;
			idex_rd <= instr[11:8];
			idex_regwrite <= regwrite;
			idex_memtoreg <= (op == OP_LW);
			idex_memwrite <= (op == OP_SW);
			idex_halt <= halt_seen;
		end
	end

	// Load-use stall and branch flush never meet in decode
	a_stall_flush_apart: assert property (@(posedge clk) disable iff (reset)
		!(stall && flush));

endmodule

/* src/ex_mem_if.sv */
`timescale 1ns/1ps

// EX/MEM pipeline register contents
interface ex_mem_if import cpu_pkg::*; ();
	logic regwrite;
	logic memtoreg;
	logic memwrite;
	reg_idx_t rd;
	word_t result;	// ALU, PCS, LHB or LLB value
	word_t addr;
	word_t store_data;
	logic halt;

	modport producer(output regwrite, memtoreg, memwrite, rd, result, addr, store_data, halt);
	modport consumer(input regwrite, memtoreg, memwrite, rd, result, addr, store_data, halt);
	// Forwarding only needs the destination
	modport monitor(input regwrite, rd);

endinterface

/* src/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input word_t idex_pc,
	input word_t idex_instr,
	input opcode_t idex_op,
	input word_t idex_data1,
	input word_t idex_data2,
	input reg_idx_t idex_rd,
	input logic idex_regwrite,
	input logic idex_memtoreg,
	input logic idex_memwrite,
	input logic idex_halt,
	input fwd_sel_t fwd_a,
	input fwd_sel_t fwd_b,
	input word_t mem_fwd,
	input word_t wb_data,
	ex_mem_if.producer em,
	output logic branch_taken,
	output word_t branch_target
);
	word_t opa, opb, alu_res, sum, result, base, addr;
	logic [31:0] rot;
	logic [3:0] imm4;
	logic ovf, cond_ok;
	flags_t flags, flag_we;

	assign imm4 = idex_instr[3:0];

	// Operand forwarding
	assign opa = (fwd_a == FWD_MEM) ? mem_fwd : (fwd_a == FWD_WB) ? wb_data : idex_data1;
	assign opb = (fwd_b == FWD_MEM) ? mem_fwd : (fwd_b == FWD_WB) ? wb_data : idex_data2;

	// -------------------------------------------------------------------------
	// ALU and flag register
	// -------------------------------------------------------------------------
	always_comb begin
		sum = (idex_op == OP_SUB) ? opa - opb : opa + opb;
		// Overflow when the sign flips against the operands
		if (idex_op == OP_SUB)
			ovf = (opa[15] != opb[15]) && (sum[15] != opa[15]);
		else
			ovf = (opa[15] == opb[15]) && (sum[15] != opa[15]);
		rot = {opa, opa} >> imm4;
		flag_we = '{z: 1'b1, v: 1'b0, n: 1'b0};
		case (idex_op)
			OP_ADD, OP_SUB: begin
				alu_res = ovf ? (opa[15] ? 16'h8000 : 16'h7fff) : sum;
				flag_we = '{z: 1'b1, v: 1'b1, n: 1'b1};
			end
			OP_XOR: alu_res = opa ^ opb;
			OP_AND: alu_res = opa & opb;
			OP_SLL: alu_res = opa << imm4;
			OP_SRA: alu_res = $signed(opa) >>> imm4;
			OP_ROR: alu_res = rot[15:0];
			default: begin
				alu_res = sum;
				flag_we = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			flags <= '0;
		else begin
			if (flag_we.z)
				flags.z <= (alu_res == '0);
			if (flag_we.v)
				flags.v <= ovf;
			if (flag_we.n)
				flags.n <= alu_res[15];
		end
	end

	// Value headed for rd when not a load
	always_comb begin
		case (idex_op)
			OP_LHB: result = {idex_instr[7:0], opa[7:0]};
			OP_LLB: result = {opa[15:8], idex_instr[7:0]};
			OP_PCS: result = idex_pc;
			default: result = alu_res;
		endcase
	end

	// -------------------------------------------------------------------------
	// Branch resolution
	// -------------------------------------------------------------------------
	always_comb begin
		case (cond_t'(idex_instr[11:9]))
			COND_NE: cond_ok = !flags.z;
			COND_EQ: cond_ok = flags.z;
			COND_GT: cond_ok = !flags.z && !flags.n;
			COND_LT: cond_ok = flags.n;
			COND_GE: cond_ok = flags.z || !flags.n;
			COND_LE: cond_ok = flags.z || flags.n;
			COND_OV: cond_ok = flags.v;
			COND_ALWAYS: cond_ok = 1'b1;
		endcase
	end

	assign branch_taken = (idex_op == OP_BR) || (idex_op == OP_B && cond_ok);
	// Word offset from pc+2, or register target
	assign branch_target = (idex_op == OP_BR) ? opa :
		idex_pc + {{6{idex_instr[8]}}, idex_instr[8:0], 1'b0};

	// Even base plus signed imm4 words
	assign base = (idex_op == OP_SW) ? opb : opa;
	assign addr = {base[15:1], 1'b0} + {{11{imm4[3]}}, imm4, 1'b0};

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (reset) begin
			em.regwrite <= 1'b0;
			em.memtoreg <= 1'b0;
			em.memwrite <= 1'b0;
			em.halt <= 1'b0;
		end else begin
			em.regwrite <= idex_regwrite;
			em.memtoreg <= idex_memtoreg;
			em.memwrite <= idex_memwrite;
			em.halt <= idex_halt;
		end
		em.rd <= idex_rd;
		em.result <= result;
		em.addr <= addr;
		em.store_data <= opa;
	end

	a_fwd_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown({fwd_a, fwd_b}));
	// Flush must land a bubble right behind a taken branch
	a_flush_bubble: assert property (@(posedge clk) disable iff (reset)
		branch_taken |=> idex_op == OP_NOP && !branch_taken);

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	input logic imem_we,
	input logic [IMEM_AW-1:0] imem_addr,
	input word_t imem_wdata,
	input logic stall,
	input logic halt_seen,
	input logic branch_taken,
	input word_t branch_target,
	output word_t pc,
	output word_t ifid_pc,
	output word_t ifid_instr,
	output logic ifid_valid
);
	word_t imem [IMEM_DEPTH];
	word_t pc_plus2;
	logic halted;

	assign pc_plus2 = pc + 16'd2;

	// Program load port, only open under reset
	always_ff @(posedge clk)
		if (reset && imem_we)
			imem[imem_addr] <= imem_wdata;

	// PC and IF/ID valid
	// Branch beats stall, stall beats halt
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			ifid_valid <= 1'b0;
			halted <= 1'b0;
		end else if (branch_taken) begin
			pc <= branch_target;
			ifid_valid <= 1'b0;
		end else if (!stall) begin
			if (halt_seen || halted) begin
				// PC parked, only bubbles from here on
				halted <= 1'b1;
				ifid_valid <= 1'b0;
			end else begin
				pc <= pc_plus2;
				ifid_valid <= 1'b1;
			end
		end
	end

	// IF/ID payload, pc+2 travels with the word
	always_ff @(posedge clk)
		if (!stall) begin
			ifid_pc <= pc_plus2;
			ifid_instr <= imem[pc[IMEM_AW:1]];
		end

	a_load_in_reset: assert property (@(posedge clk) imem_we |-> reset);

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
	input reg_idx_t idex_rs,
	input reg_idx_t idex_rt,
	input logic idex_memtoreg,
	input reg_idx_t idex_rd,
	input reg_idx_t ifid_rs,
	input reg_idx_t ifid_rt,
	ex_mem_if.monitor em,
	input logic wb_en,
	input reg_idx_t wb_rd,
	output logic stall,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b
);
	// Load in EX feeding decode, hold one cycle
	// Unused fields may match too, costs a cycle at worst
	assign stall = idex_memtoreg && (idex_rd == ifid_rs || idex_rd == ifid_rt);

	// Youngest producer wins
	always_comb begin
		if (em.regwrite && em.rd == idex_rs)
			fwd_a = FWD_MEM;
		else if (wb_en && wb_rd == idex_rs)
			fwd_a = FWD_WB;
		else
			fwd_a = FWD_NONE;

		if (em.regwrite && em.rd == idex_rt)
			fwd_b = FWD_MEM;
		else if (wb_en && wb_rd == idex_rt)
			fwd_b = FWD_WB;
		else
			fwd_b = FWD_NONE;
	end

endmodule

/* src/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; (
	input logic clk,
	input logic reset,
	ex_mem_if.consumer em,
	output word_t mem_fwd,
	output logic wb_en,
	output reg_idx_t wb_rd,
	output word_t wb_data,
	output logic hlt
);
	word_t dmem [DMEM_DEPTH];
	logic [DMEM_AW-1:0] widx;

	// Byte address to word index
	assign widx = em.addr[DMEM_AW:1];

	// -------------------------------------------------------------------------
	// Data memory
	// -------------------------------------------------------------------------
	always_ff @(posedge clk)
		if (em.memwrite)
			dmem[widx] <= em.store_data;

	// Read is combinational, load or pass the EX result
	assign mem_fwd = em.memtoreg ? dmem[widx] : em.result;

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_en <= 1'b0;
			hlt <= 1'b0;
		end else begin
			wb_en <= em.regwrite;
			// Sticky until reset
			hlt <= hlt | em.halt;
		end
		wb_rd <= em.rd;
		wb_data <= mem_fwd;
	end

endmodule
